//--- source/dcache_pkg.sv
package dcache_pkg;

    // word and line geometry
    localparam int WORD_W         = 32;
    localparam int WORDS_PER_LINE = 4;
    localparam int LINE_W         = WORD_W * WORDS_PER_LINE;
    localparam int OFFSET_W       = 4;   // byte offset within a line
    localparam int ADDR_W         = 32;
    localparam int STRB_W         = WORD_W / 8;

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [STRB_W-1:0] wstrb_t;
    typedef logic [LINE_W-1:0] line_t;   // word 0 in the low bits

    // one CPU access, as issued and as buffered for its lookup cycle
    typedef struct packed {
        logic   op;      // 1 = store
        addr_t  addr;
        word_t  wdata;
        wstrb_t wstrb;
    } cpu_req_t;

    // victim line on its way back to memory
    typedef struct packed {
        addr_t addr;     // line aligned
        line_t data;
    } mem_wr_t;

endpackage

//--- source/dcache_ctrl.sv
`timescale 1ns/1ps

module dcache_ctrl (
    input  logic                 clk,
    input  logic                 reset,

    input  logic                 req_valid,
    input  dcache_pkg::cpu_req_t req,

    input  logic                 hit,
    input  logic                 victim_dirty,

    input  logic                 mem_rd_rdy,
    input  logic                 mem_ret_valid,
    input  logic                 mem_wr_rdy,
    input  logic                 mem_wr_done,

    output logic                 busy,
    output logic                 mem_rd_req,
    output dcache_pkg::addr_t    mem_rd_addr,
    output logic                 mem_wr_req,

    output logic                 lookup_en,
    output dcache_pkg::addr_t    lookup_addr,
    output dcache_pkg::cpu_req_t buf_req,
    output logic                 commit,
    output logic                 refill_we
);
    import dcache_pkg::*;

    typedef enum logic [2:0] {
        LOOKUP,
        MISS_DIRTY,
        WRITEBACK,
        MISS_CLEAN,
        REFILL,
        REFILL_DONE
    } cache_state_e;

    cache_state_e state;
    cache_state_e next_state;
    logic         buf_valid;   // buffered request is in its lookup cycle
    logic         miss;

    // request buffer held through the whole miss sequence
    always_ff @(posedge clk) begin
        if (req_valid)
            buf_req <= req;
    end

    always_ff @(posedge clk) begin
        if (reset)
            buf_valid <= 1'b0;
        else
            buf_valid <= lookup_en;   // refill done replays the buffered request
    end

    assign lookup_en   = req_valid || (state == REFILL_DONE);
    assign lookup_addr = (state == REFILL_DONE) ? buf_req.addr : req.addr;

    assign miss      = (state == LOOKUP) && buf_valid && !hit;
    assign busy      = (state != LOOKUP) || miss;
    assign commit    = (state == LOOKUP) && buf_valid && hit && buf_req.op;
    assign refill_we = (state == REFILL) && mem_ret_valid;

    assign mem_rd_req  = (state == MISS_CLEAN);
    assign mem_wr_req  = (state == MISS_DIRTY);
    assign mem_rd_addr = buf_req.addr & ~addr_t'((1 << OFFSET_W) - 1);

    always_ff @(posedge clk) begin
        if (reset)
            state <= LOOKUP;
        else
            state <= next_state;
    end

    always_comb begin
        next_state = state;
        case (state)
            LOOKUP: begin
                if (miss)
                    next_state = victim_dirty ? MISS_DIRTY : MISS_CLEAN;
            end
            MISS_DIRTY: begin
                if (mem_wr_rdy)
                    next_state = WRITEBACK;
            end
            WRITEBACK: begin
                if (mem_wr_done)
                    next_state = MISS_CLEAN;
            end
            MISS_CLEAN: begin
                if (mem_rd_rdy)
                    next_state = REFILL;
            end
            REFILL: begin
                if (mem_ret_valid)
                    next_state = REFILL_DONE;
            end
            REFILL_DONE: next_state = LOOKUP;   // one cycle of relookup
            default:     next_state = LOOKUP;
        endcase
    end

    // the CPU must hold off while the cache is busy
    a_no_req_when_busy: assert property (
        @(posedge clk) disable iff (reset) req_valid |-> !busy
    ) else $error("req_valid=%h while busy=%h", req_valid, busy);

endmodule

//--- source/dcache_tag_store.sv
`timescale 1ns/1ps

module dcache_tag_store #(
    parameter  int LINE_COUNT = 256,
    localparam int INDEX_W    = $clog2(LINE_COUNT),
    localparam int TAG_W      = dcache_pkg::ADDR_W - INDEX_W - dcache_pkg::OFFSET_W
) (
    input  logic                 clk,
    input  logic                 reset,

    input  logic                 lookup_en,
    input  dcache_pkg::addr_t    lookup_addr,
    input  dcache_pkg::cpu_req_t buf_req,
    input  logic                 commit,
    input  logic                 refill_we,

    output logic                 hit,
    output logic                 victim_dirty,
    output logic [TAG_W-1:0]     victim_tag
);
    import dcache_pkg::*;

    typedef logic [INDEX_W-1:0] index_t;
    typedef logic [TAG_W-1:0]   tag_t;

    logic [LINE_COUNT-1:0] valid_q;
    logic [LINE_COUNT-1:0] dirty_q;
    tag_t                  tag_mem [LINE_COUNT];

    index_t lk_index;
    tag_t   lk_tag;
    index_t buf_index;
    tag_t   buf_tag;
    logic   lk_dirty;

    assign lk_index  = lookup_addr[OFFSET_W +: INDEX_W];
    assign lk_tag    = lookup_addr[OFFSET_W + INDEX_W +: TAG_W];
    assign buf_index = buf_req.addr[OFFSET_W +: INDEX_W];
    assign buf_tag   = buf_req.addr[OFFSET_W + INDEX_W +: TAG_W];

    // dirty only counts on a valid line, commit to the same line forwards
    assign lk_dirty = valid_q[lk_index] &&
                      (dirty_q[lk_index] || (commit && buf_index == lk_index));

    always_ff @(posedge clk) begin
        if (reset)
            valid_q <= '0;
        else if (refill_we)
            valid_q[buf_index] <= 1'b1;
    end

    always_ff @(posedge clk) begin
        if (refill_we) begin
            tag_mem[buf_index] <= buf_tag;
            dirty_q[buf_index] <= 1'b0;   // fresh line from memory
        end else if (commit) begin
            dirty_q[buf_index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            hit          <= 1'b0;
            victim_dirty <= 1'b0;
        end else if (lookup_en) begin
            hit          <= valid_q[lk_index] && (tag_mem[lk_index] == lk_tag);
            victim_dirty <= lk_dirty;
        end
    end

    always_ff @(posedge clk) begin
        if (lookup_en)
            victim_tag <= tag_mem[lk_index];   // write-back address
    end

    // a store commits only on a hit, never while a line is arriving
    a_refill_commit_excl: assert property (
        @(posedge clk) disable iff (reset) !(refill_we && commit)
    ) else $error("refill_we and commit high together");

endmodule

//--- source/dcache_data_store.sv
`timescale 1ns/1ps

module dcache_data_store #(
    parameter  int LINE_COUNT = 256,
    localparam int INDEX_W    = $clog2(LINE_COUNT),
    localparam int TAG_W      = dcache_pkg::ADDR_W - INDEX_W - dcache_pkg::OFFSET_W
) (
    input  logic                 clk,
    input  logic                 reset,

    input  logic                 lookup_en,
    input  dcache_pkg::addr_t    lookup_addr,
    input  dcache_pkg::cpu_req_t buf_req,
    input  logic                 commit,
    input  logic                 refill_we,
    input  dcache_pkg::line_t    mem_ret_data,
    input  logic [TAG_W-1:0]     victim_tag,

    output dcache_pkg::word_t    rdata,
    output dcache_pkg::mem_wr_t  mem_wr
);
    import dcache_pkg::*;

    localparam int WSEL_W = $clog2(WORDS_PER_LINE);

    typedef logic [INDEX_W-1:0] index_t;
    typedef logic [WSEL_W-1:0]  wsel_t;

    line_t  line_mem [LINE_COUNT];
    line_t  rd_line;      // line read at lookup_en
    line_t  rd_patched;

    index_t lk_index;
    index_t buf_index;
    wsel_t  buf_wsel;
    word_t  rd_word;
    word_t  merged;

    // one-entry write buffer
    logic   wb_valid;
    logic   wb_write;
    index_t wb_index;
    wsel_t  wb_wsel;
    word_t  wb_data;

    assign lk_index  = lookup_addr[OFFSET_W +: INDEX_W];
    assign buf_index = buf_req.addr[OFFSET_W +: INDEX_W];
    assign buf_wsel  = buf_req.addr[OFFSET_W-1 -: WSEL_W];

    assign rd_word = rd_line[buf_wsel*WORD_W +: WORD_W];
    assign rdata   = rd_word;

    // strobed bytes from the store, the rest from the cached word
    always_comb begin
        for (int b = 0; b < STRB_W; b++)
            merged[8*b +: 8] = buf_req.wstrb[b] ? buf_req.wdata[8*b +: 8] : rd_word[8*b +: 8];
    end

    // newer stores are not in the array yet, lay them over the read
    always_comb begin
        rd_patched = line_mem[lk_index];
        if (wb_valid && wb_index == lk_index)
            rd_patched[wb_wsel*WORD_W +: WORD_W] = wb_data;
        if (commit && buf_index == lk_index)
            rd_patched[buf_wsel*WORD_W +: WORD_W] = merged;   // newest wins
    end

    always_ff @(posedge clk) begin
        if (lookup_en)
            rd_line <= rd_patched;
    end

    assign wb_write = wb_valid && !refill_we;   // refill owns the write port

    always_ff @(posedge clk) begin
        if (reset)
            wb_valid <= 1'b0;
        else
            wb_valid <= commit || (wb_valid && !wb_write);
    end

    always_ff @(posedge clk) begin
        if (commit) begin
            wb_index <= buf_index;
            wb_wsel  <= buf_wsel;
            wb_data  <= merged;
        end
    end

    always_ff @(posedge clk) begin
        if (refill_we)
            line_mem[buf_index] <= mem_ret_data;
        else if (wb_write)
            line_mem[wb_index][wb_wsel*WORD_W +: WORD_W] <= wb_data;
    end

    // victim line goes out from the lookup read
    assign mem_wr.addr = {victim_tag, buf_index, {OFFSET_W{1'b0}}};
    assign mem_wr.data = rd_line;

    // a pending store must drain before the buffer takes the next one
    a_wb_no_overwrite: assert property (
        @(posedge clk) disable iff (reset) commit |-> (!wb_valid || wb_write)
    ) else $error("write buffer loaded while entry %h still pending", wb_data);

endmodule

//--- source/dcache_top.sv
`timescale 1ns/1ps

module dcache_top #(
    parameter int LINE_COUNT = 256
) (
    input  logic                 clk,
    input  logic                 reset,

    input  logic                 req_valid,
    input  dcache_pkg::cpu_req_t req,
    output dcache_pkg::word_t    rdata,
    output logic                 busy,

    output logic                 mem_rd_req,
    output dcache_pkg::addr_t    mem_rd_addr,
    input  logic                 mem_rd_rdy,
    input  logic                 mem_ret_valid,
    input  dcache_pkg::line_t    mem_ret_data,

    output logic                 mem_wr_req,
    output dcache_pkg::mem_wr_t  mem_wr,
    input  logic                 mem_wr_rdy,
    input  logic                 mem_wr_done
);
    import dcache_pkg::*;

    localparam int TAG_W = ADDR_W - $clog2(LINE_COUNT) - OFFSET_W;

    logic             lookup_en;
    addr_t            lookup_addr;
    cpu_req_t         buf_req;
    logic             commit;
    logic             refill_we;
    logic             hit;
    logic             victim_dirty;
    logic [TAG_W-1:0] victim_tag;

    dcache_ctrl ctrl_inst (
        .clk           (clk),
        .reset         (reset),
        .req_valid     (req_valid),
        .req           (req),
        .hit           (hit),
        .victim_dirty  (victim_dirty),
        .mem_rd_rdy    (mem_rd_rdy),
        .mem_ret_valid (mem_ret_valid),
        .mem_wr_rdy    (mem_wr_rdy),
        .mem_wr_done   (mem_wr_done),
        .busy          (busy),
        .mem_rd_req    (mem_rd_req),
        .mem_rd_addr   (mem_rd_addr),
        .mem_wr_req    (mem_wr_req),
        .lookup_en     (lookup_en),
        .lookup_addr   (lookup_addr),
        .buf_req       (buf_req),
        .commit        (commit),
        .refill_we     (refill_we)
    );

    dcache_tag_store #(.LINE_COUNT(LINE_COUNT)) tag_store_inst (
        .clk          (clk),
        .reset        (reset),
        .lookup_en    (lookup_en),
        .lookup_addr  (lookup_addr),
        .buf_req      (buf_req),
        .commit       (commit),
        .refill_we    (refill_we),
        .hit          (hit),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag)
    );

    dcache_data_store #(.LINE_COUNT(LINE_COUNT)) data_store_inst (
        .clk          (clk),
        .reset        (reset),
        .lookup_en    (lookup_en),
        .lookup_addr  (lookup_addr),
        .buf_req      (buf_req),
        .commit       (commit),
        .refill_we    (refill_we),
        .mem_ret_data (mem_ret_data),
        .victim_tag   (victim_tag),
        .rdata        (rdata),
        .mem_wr       (mem_wr)
    );

endmodule

//--- testbench/tb_mem_model.sv
`timescale 1ns/1ps

module tb_mem_model #(
    parameter dcache_pkg::addr_t BASE = 32'h0000_1000
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                mem_rd_req,
    input  dcache_pkg::addr_t   mem_rd_addr,
    output logic                mem_rd_rdy,
    output logic                mem_ret_valid,
    output dcache_pkg::line_t   mem_ret_data,
    input  logic                mem_wr_req,
    input  dcache_pkg::mem_wr_t mem_wr,
    output logic                mem_wr_rdy,
    output logic                mem_wr_done,
    output logic                proto_error
);
    import dcache_pkg::*;

    word_t       backing [64];
    logic [31:0] rng_state = 32'h8b4d_2d7b;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic word_t fill_word(input addr_t a);
        return (a * 32'h9e37_79b9) ^ {a[15:0], a[31:16]};
    endfunction

    task automatic flag_error(input string what);
        $display("** Error: %s", what);
        proto_error = 1'b1;
    endtask

    task automatic wait_random();
        int n;
        rng_state = xorshift(rng_state);
        n = int'(rng_state % 32'd6);   // 0 to 5 cycles
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    // first word of a line inside the window
    function automatic int line_base(input addr_t a);
        return int'((a - BASE) >> 4) * 4;
    endfunction

    task automatic serve_write();
        mem_wr_t wr;
        wait_random();
        mem_wr_rdy = 1'b1;
        wr = mem_wr;
        @(posedge clk);
        #1;
        mem_wr_rdy = 1'b0;
        if (wr.addr < BASE || wr.addr >= BASE + 32'd256)
            flag_error($sformatf("write-back address %h outside the window", wr.addr));
        else
            for (int w = 0; w < 4; w++)
                backing[line_base(wr.addr) + w] = wr.data[w*32 +: 32];
        wait_random();
        mem_wr_done = 1'b1;
        @(posedge clk);
        #1;
        mem_wr_done = 1'b0;
    endtask

    task automatic serve_read();
        addr_t a;
        wait_random();
        mem_rd_rdy = 1'b1;
        a = mem_rd_addr;
        @(posedge clk);
        #1;
        mem_rd_rdy = 1'b0;
        if (a < BASE || a >= BASE + 32'd256)
            flag_error($sformatf("read address %h outside the window", a));
        wait_random();
        for (int w = 0; w < 4; w++)
            mem_ret_data[w*32 +: 32] = backing[(line_base(a) + w) % 64];
        mem_ret_valid = 1'b1;
        @(posedge clk);
        #1;
        mem_ret_valid = 1'b0;
    endtask

    initial begin
        mem_rd_rdy    = 1'b0;
        mem_ret_valid = 1'b0;
        mem_ret_data  = '0;
        mem_wr_rdy    = 1'b0;
        mem_wr_done   = 1'b0;
        proto_error   = 1'b0;
        for (int i = 0; i < 64; i++)
            backing[i] = fill_word(BASE + addr_t'(i * 4));
        forever begin
            @(posedge clk);
            #1;
            if (!reset && mem_wr_req)
                serve_write();
            else if (!reset && mem_rd_req)
                serve_read();
        end
    end

    // request and its payload held steady under back-pressure
    a_rd_hold: assert property (@(posedge clk) disable iff (reset)
        mem_rd_req && !mem_rd_rdy |=> mem_rd_req && $stable(mem_rd_addr))
        else flag_error("mem_rd_req dropped or mem_rd_addr changed while not ready");

    a_wr_hold: assert property (@(posedge clk) disable iff (reset)
        mem_wr_req && !mem_wr_rdy |=> mem_wr_req && $stable(mem_wr))
        else flag_error("mem_wr_req dropped or mem_wr changed while not ready");

endmodule

//--- testbench/tb_dcache.sv
`timescale 1ns/1ps

module tb_dcache;
    import dcache_pkg::*;

    localparam int    LINE_COUNT = 4;
    localparam int    NUM_REQ    = 400;
    localparam int    MAX_CYCLES = NUM_REQ * 40;
    localparam addr_t BASE       = 32'h0000_1000;   // 64-word window

    logic     clk = 1'b0;
    logic     reset;
    logic     req_valid;
    cpu_req_t req;
    word_t    rdata;
    logic     busy;
    logic     mem_rd_req;
    addr_t    mem_rd_addr;
    logic     mem_rd_rdy;
    logic     mem_ret_valid;
    line_t    mem_ret_data;
    logic     mem_wr_req;
    mem_wr_t  mem_wr;
    logic     mem_wr_rdy;
    logic     mem_wr_done;
    logic     proto_error;

    // shadow of what the CPU should see
    word_t       shadow_mem [64];
    logic [3:0]  sh_valid;
    logic [3:0]  sh_dirty;
    logic [25:0] sh_tag [4];

    // prediction for the request in its lookup / miss phase
    cpu_req_t lk_req;
    logic     lk_cycle;
    logic     lk_hit;
    logic     lk_dirty_miss;
    addr_t    lk_line_addr;
    addr_t    lk_wr_addr;
    line_t    lk_wr_data;
    word_t    lk_rdata;
    int       lk_rd_base;
    int       lk_wr_base;
    logic     cmp_valid;
    logic     started;

    int          rd_count;
    int          wr_count;
    int          cycle_count = 0;
    logic [31:0] rng_state = 32'h8b4d_2d7b;

    always #4 clk = ~clk;

    dcache_top #(.LINE_COUNT(LINE_COUNT)) dcache_top_inst (
        .clk           (clk),
        .reset         (reset),
        .req_valid     (req_valid),
        .req           (req),
        .rdata         (rdata),
        .busy          (busy),
        .mem_rd_req    (mem_rd_req),
        .mem_rd_addr   (mem_rd_addr),
        .mem_rd_rdy    (mem_rd_rdy),
        .mem_ret_valid (mem_ret_valid),
        .mem_ret_data  (mem_ret_data),
        .mem_wr_req    (mem_wr_req),
        .mem_wr        (mem_wr),
        .mem_wr_rdy    (mem_wr_rdy),
        .mem_wr_done   (mem_wr_done)
    );

    tb_mem_model #(.BASE(BASE)) mem_model_inst (
        .clk           (clk),
        .reset         (reset),
        .mem_rd_req    (mem_rd_req),
        .mem_rd_addr   (mem_rd_addr),
        .mem_rd_rdy    (mem_rd_rdy),
        .mem_ret_valid (mem_ret_valid),
        .mem_ret_data  (mem_ret_data),
        .mem_wr_req    (mem_wr_req),
        .mem_wr        (mem_wr),
        .mem_wr_rdy    (mem_wr_rdy),
        .mem_wr_done   (mem_wr_done),
        .proto_error   (proto_error)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic word_t initial_word(input addr_t a);
        return (a * 32'h9e37_79b9) ^ {a[15:0], a[31:16]};
    endfunction

    task automatic report_value(input string name, input string got, input string exp);
        $display("** Error: %s got %s expected %s", name, got, exp);
        $display("Some tests failed");
        $fatal(1, "value mismatch on %s", name);
    endtask

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Some tests failed");
        $fatal(1, "check failed");
    endtask

    always @(posedge clk) begin
        if (reset) begin
            rd_count <= 0;
            wr_count <= 0;
        end else begin
            if (mem_rd_req && mem_rd_rdy)
                rd_count <= rd_count + 1;
            if (mem_wr_req && mem_wr_rdy)
                wr_count <= wr_count + 1;
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("timeout, the run did not finish within %0d cycles", MAX_CYCLES);
            $display("Some tests failed");
            $fatal(1, "timeout");
        end
    end

    a_idle_after_reset: assert property (@(posedge clk) disable iff (reset)
        !started |-> !busy && !mem_rd_req && !mem_wr_req)
        else report_failure("cache went active before the first request");

    a_hit_no_stall: assert property (@(posedge clk) disable iff (reset)
        lk_cycle && lk_hit |-> !busy && !mem_rd_req && !mem_wr_req)
        else report_failure("predicted hit stalled or reached memory");

    a_miss_stalls: assert property (@(posedge clk) disable iff (reset)
        lk_cycle && !lk_hit |-> busy)
        else report_failure("predicted miss completed in its lookup cycle");

    a_busy_on_mem: assert property (@(posedge clk) disable iff (reset)
        (mem_rd_req || mem_wr_req) |-> busy)
        else report_failure("busy low while a memory request is pending");

    a_rd_addr: assert property (@(posedge clk) disable iff (reset)
        mem_rd_req |-> mem_rd_addr == lk_line_addr)
        else report_value("mem_rd_addr", $sformatf("%h", $sampled(mem_rd_addr)),
                          $sformatf("%h", $sampled(lk_line_addr)));

    a_wr_expected: assert property (@(posedge clk) disable iff (reset)
        mem_wr_req |-> lk_dirty_miss)
        else report_failure("write-back issued for a clean victim");

    a_wr_addr: assert property (@(posedge clk) disable iff (reset)
        mem_wr_req |-> mem_wr.addr == lk_wr_addr)
        else report_value("mem_wr.addr", $sformatf("%h", $sampled(mem_wr.addr)),
                          $sformatf("%h", $sampled(lk_wr_addr)));

    a_wr_data: assert property (@(posedge clk) disable iff (reset)
        mem_wr_req |-> mem_wr.data == lk_wr_data)
        else report_value("mem_wr.data", $sformatf("%h", $sampled(mem_wr.data)),
                          $sformatf("%h", $sampled(lk_wr_data)));

    // the victim must be written before the refill starts
    a_wr_before_rd: assert property (@(posedge clk) disable iff (reset)
        mem_rd_req |-> (wr_count - lk_wr_base) == (lk_dirty_miss ? 1 : 0))
        else report_failure("mem_rd_req raised before the victim write-back");

    a_mem_traffic: assert property (@(posedge clk) disable iff (reset)
        cmp_valid |-> (rd_count - lk_rd_base) == (lk_hit ? 0 : 1) &&
                      (wr_count - lk_wr_base) == (lk_dirty_miss ? 1 : 0))
        else report_failure("wrong number of memory transactions for a request");

    a_load_data: assert property (@(posedge clk) disable iff (reset)
        cmp_valid && !lk_req.op |-> rdata == lk_rdata)
        else report_value("rdata", $sformatf("%h", $sampled(rdata)),
                          $sformatf("%h", $sampled(lk_rdata)));

    a_bus_protocol: assert property (@(posedge clk) disable iff (reset) !proto_error)
        else report_failure("memory bus protocol violation");

    // predict the outcome from the shadow state at lookup time
    task automatic predict(input cpu_req_t r);
        logic [1:0]  idx;
        logic [25:0] tag;
        int          vbase;
        idx = r.addr[5:4];
        tag = r.addr[31:6];
        lk_req        = r;
        lk_hit        = sh_valid[idx] && sh_tag[idx] == tag;
        lk_dirty_miss = !lk_hit && sh_valid[idx] && sh_dirty[idx];
        lk_line_addr  = {r.addr[31:4], 4'b0000};
        lk_wr_addr    = {sh_tag[idx], idx, 4'b0000};
        lk_rdata      = shadow_mem[int'(r.addr[7:2])];
        vbase = int'(lk_wr_addr[7:4]) * 4;
        for (int w = 0; w < 4; w++)
            lk_wr_data[w*32 +: 32] = shadow_mem[vbase + w];
    endtask

    task automatic complete();
        logic [1:0] idx;
        int         w;
        idx = lk_req.addr[5:4];
        w   = int'(lk_req.addr[7:2]);
        sh_valid[idx] = 1'b1;
        sh_tag[idx]   = lk_req.addr[31:6];
        if (!lk_hit)
            sh_dirty[idx] = 1'b0;
        if (lk_req.op) begin
            for (int b = 0; b < 4; b++)
                if (lk_req.wstrb[b])
                    shadow_mem[w][8*b +: 8] = lk_req.wdata[8*b +: 8];
            sh_dirty[idx] = 1'b1;
        end
    endtask

    task automatic run_request();
        cpu_req_t r;
        rng_state = xorshift(rng_state);
        r.addr    = BASE + {24'b0, rng_state[5:0], 2'b00};
        r.op      = rng_state[8];
        r.wstrb   = (rng_state[12:9] == 4'b0) ? 4'hf : rng_state[12:9];
        rng_state = xorshift(rng_state);
        r.wdata   = rng_state;
        req_valid = 1'b1;
        req       = r;
        started   = 1'b1;
        @(posedge clk);
        #1;
        req_valid  = 1'b0;
        cmp_valid  = 1'b0;
        predict(r);
        lk_rd_base = rd_count;
        lk_wr_base = wr_count;
        lk_cycle   = 1'b1;
        while (busy) begin
            @(posedge clk);
            #1;
            lk_cycle = 1'b0;
        end
        cmp_valid = 1'b1;
        complete();
    endtask

    initial begin
        reset     = 1'b1;
        req_valid = 1'b0;
        req       = '0;
        started   = 1'b0;
        lk_cycle  = 1'b0;
        cmp_valid = 1'b0;
        lk_req    = '0;
        sh_valid  = '0;
        sh_dirty  = '0;
        for (int i = 0; i < 64; i++)
            shadow_mem[i] = initial_word(BASE + addr_t'(i * 4));
        for (int i = 0; i < 4; i++)
            sh_tag[i] = '0;
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;
        repeat (3) @(posedge clk);   // idle check window
        #1;
        for (int n = 0; n < NUM_REQ; n++)
            run_request();
        @(posedge clk);
        #1;
        cmp_valid = 1'b0;
        lk_cycle  = 1'b0;
        @(posedge clk);
        if (!proto_error) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- src.f
source/dcache_pkg.sv
source/dcache_ctrl.sv
source/dcache_tag_store.sv
source/dcache_data_store.sv
source/dcache_top.sv
testbench/tb_mem_model.sv
testbench/tb_dcache.sv

//--- run_sim.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
    --top-module tb_dcache \
    -f src.f \
    -o Vtb_dcache

./obj_dir/Vtb_dcache | tee sim.log

if grep -q "All tests passed" sim.log; then
    echo "simulation PASSED"
else
    echo "simulation FAILED"
    exit 1
fi
